// ==== verilog.f ====
+incdir+include
src/lc3b_types.sv
src/control_rom.sv
src/regfile.sv
src/decode_stage.sv
src/execute_stage.sv
src/lc3b_core.sv
sim/lc3b_checker.sv
sim/lc3b_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of the LC-3b decode/execute testbench

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
	-f verilog.f \
	--top-module lc3b_core_tb \
	--Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/Vlc3b_core_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qF '*** TEST PASSED ***' "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== sim/lc3b_core_tb.sv ====
`timescale 1ns/1ps

module lc3b_core_tb import lc3b_types::*; ();

localparam int NUM_ENTRIES = 24;
localparam int RESET_CYCLES = 16;
localparam int TIMEOUT_CYCLES = 40 * NUM_ENTRIES + RESET_CYCLES;

logic clk;
logic arst_n;
logic in_valid;
logic in_ready;
lc3b_fetch_pkt in_pkt;
logic out_valid;
logic out_ready;
lc3b_retire_pkt out_pkt;
// Table values riding along with each instruction
lc3b_word exp_value;
logic [2:0] exp_cc;
int field_errors;
int table_errors;
int stream_errors;
int retired;
int cycles;

// Instruction, expected value and expected cc per entry
// Value is the result, the memory address or the branch target
lc3b_word tbl_inst [NUM_ENTRIES];
lc3b_word tbl_value [NUM_ENTRIES];
logic [2:0] tbl_cc [NUM_ENTRIES];

lc3b_core dut_i (
	.clk(clk),
	.arst_n(arst_n),
	.in_valid(in_valid),
	.in_ready(in_ready),
	.in_pkt(in_pkt),
	.out_valid(out_valid),
	.out_ready(out_ready),
	.out_pkt(out_pkt)
);

lc3b_checker checker_i (
	.clk(clk),
	.arst_n(arst_n),
	.in_valid(in_valid),
	.in_ready(in_ready),
	.in_pkt(in_pkt),
	.exp_value(exp_value),
	.exp_cc(exp_cc),
	.out_valid(out_valid),
	.out_ready(out_ready),
	.out_pkt(out_pkt),
	.field_errors(field_errors),
	.table_errors(table_errors),
	.stream_errors(stream_errors),
	.retired(retired)
);

function automatic lc3b_word operate_reg(input logic [3:0] opc, input lc3b_reg dr,
		input lc3b_reg sr1, input lc3b_reg sr2);
	return {opc, dr, sr1, 3'b000, sr2};
endfunction

function automatic lc3b_word operate_imm(input logic [3:0] opc, input lc3b_reg dr,
		input lc3b_reg sr1, input logic [4:0] imm5);
	return {opc, dr, sr1, 1'b1, imm5};
endfunction

// A is arithmetic, D is left
function automatic lc3b_word shift_word(input lc3b_reg dr, input lc3b_reg sr,
		input logic a, input logic d, input logic [3:0] amount);
	return {op_shf, dr, sr, a, d, amount};
endfunction

function automatic lc3b_word offset6_word(input logic [3:0] opc, input lc3b_reg r,
		input lc3b_reg base, input logic [5:0] off6);
	return {opc, r, base, off6};
endfunction

function automatic lc3b_word offset9_word(input logic [3:0] opc, input logic [2:0] nzp_dr,
		input logic [8:0] off9);
	return {opc, nzp_dr, off9};
endfunction

task automatic set_entry(input int idx, input lc3b_word iw, input lc3b_word value,
		input logic [2:0] cc);
	tbl_inst[idx] = iw;
	tbl_value[idx] = value;
	tbl_cc[idx] = cc;
endtask

// PC of entry i is 3000 + 2i
task automatic load_table();
	set_entry(0, operate_imm(op_add, 1, 0, 5'h05), 16'h0005, 3'b001);
	// Back-to-back on R1, #-3
	set_entry(1, operate_imm(op_add, 2, 1, 5'h1D), 16'h0002, 3'b001);
	set_entry(2, operate_reg(op_add, 3, 1, 2), 16'h0007, 3'b001);
	set_entry(3, operate_imm(op_and, 4, 3, 5'h06), 16'h0006, 3'b001);
	set_entry(4, operate_imm(op_and, 5, 4, 5'h00), 16'h0000, 3'b010);
	set_entry(5, operate_imm(op_not, 6, 3, 5'h1F), 16'hFFF8, 3'b100);
	set_entry(6, operate_reg(op_add, 7, 6, 6), 16'hFFF0, 3'b100);
	// BRn taken, BRzp not taken
	set_entry(7, offset9_word(op_br, 3'b100, 9'h004), 16'h3018, 3'b100);
	set_entry(8, offset9_word(op_br, 3'b011, 9'h1FE), 16'h300E, 3'b100);
	set_entry(9, shift_word(1, 3, 1'b0, 1'b1, 4'd3), 16'h0038, 3'b001);
	set_entry(10, shift_word(2, 7, 1'b0, 1'b0, 4'd4), 16'h0FFF, 3'b001);
	set_entry(11, shift_word(4, 7, 1'b1, 1'b0, 4'd2), 16'hFFFC, 3'b100);
	set_entry(12, offset9_word(op_br, 3'b001, 9'h003), 16'h3020, 3'b100);
	set_entry(13, offset9_word(op_br, 3'b110, 9'h1FB), 16'h3012, 3'b100);
	set_entry(14, offset9_word(op_lea, 3'd5, 9'h010), 16'h303E, 3'b001);
	set_entry(15, offset6_word(op_str, 3, 1, 6'h02), 16'h003C, 3'b001);
	// LDR must leave R6 alone, entry 17 reads it
	set_entry(16, offset6_word(op_ldr, 6, 2, 6'h3F), 16'h0FFD, 3'b001);
	set_entry(17, operate_imm(op_add, 0, 6, 5'h08), 16'h0000, 3'b010);
	set_entry(18, offset9_word(op_br, 3'b010, 9'h001), 16'h3028, 3'b010);
	// LDI is outside the supported set
	set_entry(19, 16'hA5C3, 16'h0000, 3'b010);
	set_entry(20, offset9_word(op_br, 3'b010, 9'h000), 16'h302A, 3'b010);
	set_entry(21, operate_imm(op_not, 1, 0, 5'h1F), 16'hFFFF, 3'b100);
	set_entry(22, offset6_word(op_str, 1, 0, 6'h00), 16'h0000, 3'b100);
	set_entry(23, operate_reg(op_add, 2, 1, 1), 16'hFFFE, 3'b100);
endtask

initial begin
	clk = 1'b0;
	forever #50 clk = ~clk;
end

// Run limit
initial begin
	cycles = 0;
	while (cycles < TIMEOUT_CYCLES) begin
		@(posedge clk);
		cycles++;
	end
	$display("Timeout after %0d cycles, %0d of %0d instructions retired",
		cycles, retired, NUM_ENTRIES);
	$display("*** TEST FAILED ***");
	$finish;
end

initial begin
	int gap;
	void'($urandom(32'h395e4d05));
	arst_n = 1'b0;
	in_valid = 1'b0;
	in_pkt = '0;
	out_ready = 1'b0;
	exp_value = '0;
	exp_cc = '0;
	load_table();
	repeat (RESET_CYCLES) @(posedge clk);
	@(negedge clk);
	arst_n = 1'b1;

	// Random back-pressure on the retire port, ready three times in four
	fork
		forever begin
			@(negedge clk);
			out_ready = ($urandom() % 4) != 0;
		end
	join_none

	for (int i = 0; i < NUM_ENTRIES; i++) begin
		// Optional idle cycles before the next instruction
		gap = int'($urandom() % 3);
		if (gap != 0) begin
			in_valid = 1'b0;
			repeat (gap) @(negedge clk);
		end
		in_valid = 1'b1;
		in_pkt.inst = tbl_inst[i];
		in_pkt.pc = 16'h3000 + lc3b_word'(2 * i);
		exp_value = tbl_value[i];
		exp_cc = tbl_cc[i];
		// Hold until the handshake completes
		@(posedge clk);
		while (!in_ready)
			@(posedge clk);
		@(negedge clk);
	end
	in_valid = 1'b0;

	wait (retired == NUM_ENTRIES);
	// A few more cycles to catch extra records
	repeat (8) @(posedge clk);
	$display("Errors: %0d field, %0d table, %0d stream; %0d of %0d instructions retired",
		field_errors, table_errors, stream_errors, retired, NUM_ENTRIES);
	if (field_errors == 0 && table_errors == 0 && stream_errors == 0 &&
			retired == NUM_ENTRIES) begin
		$display("*** TEST PASSED ***");
	end else begin
		$display("*** TEST FAILED ***");
	end
	$finish;
end

endmodule : lc3b_core_tb

// ==== sim/lc3b_checker.sv ====
`timescale 1ns/1ps

`include "lc3b_defines.svh"

module lc3b_checker import lc3b_types::*; (
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	input logic in_ready,
	input lc3b_fetch_pkt in_pkt,
	input lc3b_word exp_value,
	input logic [2:0] exp_cc,
	input logic out_valid,
	input logic out_ready,
	input lc3b_retire_pkt out_pkt,
	output int field_errors,
	output int table_errors,
	output int stream_errors,
	output int retired
);

// Architectural state of the reference model
lc3b_word mregs [`LC3B_NUM_REGS];
logic [2:0] mcc;
// Records accepted but not yet retired, oldest first
lc3b_retire_pkt exp_q [$];

// Apply one instruction in program order
task automatic predict(input lc3b_word iw, input lc3b_word pc, output lc3b_retire_pkt r);
	lc3b_word a;
	lc3b_word sext5;
	lc3b_word off6;
	lc3b_word off9;
	logic [31:0] ext;
	logic writes;
	r = '0;
	r.pc = pc;
	r.opcode = lc3b_opcode'(iw[15:12]);
	a = mregs[iw[8:6]];
	sext5 = {{11{iw[4]}}, iw[4:0]};
	off6 = {{9{iw[5]}}, iw[5:0], 1'b0};
	off9 = {{6{iw[8]}}, iw[8:0], 1'b0};
	// Sign fill only for an arithmetic right shift
	ext = {{16{iw[5] & a[15]}}, a};
	writes = 1'b1;
	case (lc3b_opcode'(iw[15:12]))
		op_add: r.result = a + (iw[5] ? sext5 : mregs[iw[2:0]]);
		op_and: r.result = a & (iw[5] ? sext5 : mregs[iw[2:0]]);
		op_not: r.result = ~a;
		op_shf: r.result = iw[4] ? a << iw[3:0] : lc3b_word'(ext >> iw[3:0]);
		op_lea: r.result = pc + 16'd2 + off9;
		default: writes = 1'b0;
	endcase
	case (lc3b_opcode'(iw[15:12]))
		op_ldr: begin
			r.mem_read = 1'b1;
			r.mem_addr = a + off6;
		end
		op_str: begin
			r.mem_write = 1'b1;
			r.mem_addr = a + off6;
			r.mem_wdata = mregs[iw[11:9]];
		end
		// Taken test uses the codes left by older instructions
		op_br: begin
			r.br_target = pc + 16'd2 + off9;
			r.br_taken = |(iw[11:9] & mcc);
		end
		default: ;
	endcase
	if (writes) begin
		r.wb_en = 1'b1;
		r.dest = iw[11:9];
		mregs[iw[11:9]] = r.result;
		mcc = r.result[15] ? 3'b100 : (r.result == 16'h0000) ? 3'b010 : 3'b001;
	end
	r.cc = mcc;
endtask

task automatic check_field(input string name, input lc3b_word exp, input lc3b_word act);
	if (exp !== act) begin
		field_errors++;
		$display("Fail at %0t: out_pkt.%s (pc %h) expected %h, got %h",
			$time, name, out_pkt.pc, exp, act);
	end
endtask

// Model against the hand-written table values
task automatic accept_entry();
	lc3b_retire_pkt r;
	lc3b_word value;
	predict(lc3b_word'(in_pkt.inst), in_pkt.pc, r);
	value = r.wb_en ? r.result : (r.mem_read || r.mem_write) ? r.mem_addr : r.br_target;
	if (value !== exp_value || r.cc !== exp_cc) begin
		table_errors++;
		$display("Fail at %0t: table entry pc %h value expected %h, model %h; cc expected %b, model %b",
			$time, in_pkt.pc, exp_value, value, exp_cc, r.cc);
	end
	exp_q.push_back(r);
endtask

task automatic retire_check();
	lc3b_retire_pkt e;
	if (exp_q.size() == 0) begin
		stream_errors++;
		$display("Error at %0t: DUT retired a record with pc %h that was not expected",
			$time, out_pkt.pc);
	end else begin
		e = exp_q.pop_front();
		retired++;
		check_field("pc", e.pc, out_pkt.pc);
		check_field("opcode", lc3b_word'(e.opcode), lc3b_word'(out_pkt.opcode));
		check_field("wb_en", lc3b_word'(e.wb_en), lc3b_word'(out_pkt.wb_en));
		check_field("cc", lc3b_word'(e.cc), lc3b_word'(out_pkt.cc));
		check_field("mem_read", lc3b_word'(e.mem_read), lc3b_word'(out_pkt.mem_read));
		check_field("mem_write", lc3b_word'(e.mem_write), lc3b_word'(out_pkt.mem_write));
		check_field("mem_addr", e.mem_addr, out_pkt.mem_addr);
		check_field("mem_wdata", e.mem_wdata, out_pkt.mem_wdata);
		check_field("br_taken", lc3b_word'(e.br_taken), lc3b_word'(out_pkt.br_taken));
		check_field("br_target", e.br_target, out_pkt.br_target);
		// Result and dest only matter for a register write
		if (e.wb_en) begin
			check_field("dest", lc3b_word'(e.dest), lc3b_word'(out_pkt.dest));
			check_field("result", e.result, out_pkt.result);
		end
	end
endtask

always @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		for (int i = 0; i < `LC3B_NUM_REGS; i++) begin
			mregs[i] = '0;
		end
		mcc = 3'b010;
		exp_q.delete();
		field_errors = 0;
		table_errors = 0;
		stream_errors = 0;
		retired = 0;
	end else begin
		// Pop before push, both may happen at one edge
		if (out_valid && out_ready)
			retire_check();
		if (in_valid && in_ready)
			accept_entry();
	end
end

endmodule : lc3b_checker

// ==== src/lc3b_core.sv ====
`timescale 1ns/1ps

module lc3b_core import lc3b_types::*; (
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	output logic in_ready,
	input lc3b_fetch_pkt in_pkt,
	output logic out_valid,
	input logic out_ready,
	output lc3b_retire_pkt out_pkt
);

// Decode to execute handshake
logic dx_valid;
logic dx_ready;
lc3b_dx_pkt dx_pkt;
// Write-back path back into decode
lc3b_wb_t wb;

decode_stage decode_i (
	.clk(clk),
	.arst_n(arst_n),
	.in_valid(in_valid),
	.in_ready(in_ready),
	.in_pkt(in_pkt),
	.dx_valid(dx_valid),
	.dx_ready(dx_ready),
	.dx_pkt(dx_pkt),
	.wb(wb)
);

execute_stage execute_i (
	.clk(clk),
	.arst_n(arst_n),
	.dx_valid(dx_valid),
	.dx_ready(dx_ready),
	.dx_pkt(dx_pkt),
	.wb(wb),
	.out_valid(out_valid),
	.out_ready(out_ready),
	.out_pkt(out_pkt)
);

endmodule : lc3b_core

// ==== src/execute_stage.sv ====
`timescale 1ns/1ps

`include "lc3b_defines.svh"

module execute_stage import lc3b_types::*; (
	input logic clk,
	input logic arst_n,
	input logic dx_valid,
	output logic dx_ready,
	input lc3b_dx_pkt dx_pkt,
	output lc3b_wb_t wb,
	output logic out_valid,
	input logic out_ready,
	output lc3b_retire_pkt out_pkt
);

lc3b_control_word ctrl;
lc3b_word alu_b;
lc3b_word alu_out;
lc3b_word shf_out;
lc3b_word pc_next;
lc3b_word addr_base;
lc3b_word addr_out;
lc3b_word result;
logic [2:0] cc;
logic [2:0] cc_new;
logic [2:0] cc_next;
logic dx_fire;
logic br_taken;
lc3b_retire_pkt ret;

assign ctrl = dx_pkt.ctrl;

// Retire register free when empty or draining
assign dx_ready = !out_valid || out_ready;
assign dx_fire = dx_valid && dx_ready;

// ALU, second operand is register B or the extended immediate
assign alu_b = (ctrl.alumux_sel == 2'b00) ? dx_pkt.src_b : dx_pkt.imm;

always_comb begin
	case (ctrl.alu_op)
		alu_add: alu_out = dx_pkt.src_a + alu_b;
		alu_and: alu_out = dx_pkt.src_a & alu_b;
		alu_not: alu_out = ~dx_pkt.src_a;
		default: alu_out = dx_pkt.src_a;
	endcase
end

// Shifter: bit 4 picks left, bit 5 makes a right shift arithmetic
always_comb begin
	if (dx_pkt.inst.op.sr2_imm5[4])
		shf_out = dx_pkt.src_a << dx_pkt.inst.op.sr2_imm5[3:0];
	else if (dx_pkt.inst.op.imm)
		shf_out = lc3b_word'($signed(dx_pkt.src_a) >>> dx_pkt.inst.op.sr2_imm5[3:0]);
	else
		shf_out = dx_pkt.src_a >> dx_pkt.inst.op.sr2_imm5[3:0];
end

// Address adder for LDR/STR, LEA and BR
assign pc_next = dx_pkt.pc + lc3b_word'(2);
assign addr_base = ctrl.br_addmux_sel ? dx_pkt.src_a : pc_next;
assign addr_out = addr_base + dx_pkt.imm;

always_comb begin
	case (ctrl.regfilemux_sel)
		3'b010: result = addr_out;
		3'b101: result = shf_out;
		default: result = alu_out;
	endcase
end

// Condition codes
assign cc_new = result[`LC3B_WORD_W-1] ? 3'b100 :
	(result == '0) ? 3'b010 : 3'b001;
assign cc_next = ctrl.load_cc ? cc_new : cc;

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n)
		cc <= 3'b010;
	else if (dx_fire)
		cc <= cc_next;
end

// Codes already hold every older instruction
assign br_taken = ctrl.branch && |(dx_pkt.inst.off9.nzp_dr & cc);

// Write-back only in the transfer cycle
always_comb begin
	wb.en = dx_fire && ctrl.load_regfile;
	wb.dest = dx_pkt.inst.op.dr;
	wb.value = result;
end

always_comb begin
	ret.pc = dx_pkt.pc;
	ret.opcode = dx_pkt.inst.op.opcode;
	ret.wb_en = ctrl.load_regfile;
	ret.dest = dx_pkt.inst.op.dr;
	ret.result = result;
	ret.cc = cc_next;
	ret.mem_read = ctrl.mem_read;
	ret.mem_write = ctrl.mem_write;
	// Request fields zero unless used
	ret.mem_addr = (ctrl.mem_read || ctrl.mem_write) ? addr_out : '0;
	ret.mem_wdata = ctrl.mem_write ? dx_pkt.src_b : '0;
	ret.br_taken = br_taken;
	ret.br_target = ctrl.branch ? addr_out : '0;
end

// Retire register
always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n)
		out_valid <= 1'b0;
	else if (dx_fire)
		out_valid <= 1'b1;
	else if (out_ready)
		out_valid <= 1'b0;
end

always_ff @(posedge clk) begin
	if (dx_fire)
		out_pkt <= ret;
end

out_hold: assert property (
	@(posedge clk) disable iff (!arst_n)
	(out_valid && !out_ready) |=> (out_valid && $stable(out_pkt))
);

endmodule : execute_stage

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage import lc3b_types::*; (
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	output logic in_ready,
	input lc3b_fetch_pkt in_pkt,
	output logic dx_valid,
	input logic dx_ready,
	output lc3b_dx_pkt dx_pkt,
	input lc3b_wb_t wb
);

lc3b_control_word ctrl;
lc3b_inst inst;
lc3b_reg rd_a;
lc3b_reg rd_b;
lc3b_word val_a;
lc3b_word val_b;
lc3b_word src_a;
lc3b_word src_b;
lc3b_word imm;
logic accept;

assign inst = in_pkt.inst;

control_rom control_rom_i (
	.inst(inst),
	.ctrl(ctrl)
);

// Port A is sr1, which is also the base field
// Port B is sr2, or the STR source register
assign rd_a = inst.op.sr1;
assign rd_b = ctrl.storemux_sel_two ? inst.off6.dr_sr : inst.op.sr2_imm5[2:0];

regfile regfile_i (
	.clk(clk),
	.arst_n(arst_n),
	.rd_a(rd_a),
	.rd_b(rd_b),
	.val_a(val_a),
	.val_b(val_b),
	.wb(wb)
);

// Bypass the value being written at this edge
assign src_a = (wb.en && wb.dest == rd_a) ? wb.value : val_a;
assign src_b = (wb.en && wb.dest == rd_b) ? wb.value : val_b;

// Immediate extension
always_comb begin
	case (ctrl.immmux_sel)
		2'b00: imm = lc3b_word'($signed(inst.op.sr2_imm5));
		2'b01: imm = lc3b_word'($signed({inst.off6.offset6, 1'b0}));
		2'b10: imm = lc3b_word'($signed({inst.off9.offset9, 1'b0}));
		default: imm = '0;
	endcase
end

// Register is free when empty or draining this cycle
assign in_ready = !dx_valid || dx_ready;
assign accept = in_valid && in_ready;

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n)
		dx_valid <= 1'b0;
	else if (accept)
		dx_valid <= 1'b1;
	else if (dx_ready)
		dx_valid <= 1'b0;
end

always_ff @(posedge clk) begin
	if (accept) begin
		dx_pkt.ctrl <= ctrl;
		dx_pkt.inst <= inst;
		dx_pkt.pc <= in_pkt.pc;
		dx_pkt.src_a <= src_a;
		dx_pkt.src_b <= src_b;
		dx_pkt.imm <= imm;
	end
end

// Stalled record must not move until execute takes it
dx_hold: assert property (
	@(posedge clk) disable iff (!arst_n)
	(dx_valid && !dx_ready) |=> (dx_valid && $stable(dx_pkt))
);

endmodule : decode_stage

// ==== src/regfile.sv ====
`timescale 1ns/1ps

`include "lc3b_defines.svh"

module regfile import lc3b_types::*; (
	input logic clk,
	input logic arst_n,
	input lc3b_reg rd_a,
	input lc3b_reg rd_b,
	output lc3b_word val_a,
	output lc3b_word val_b,
	input lc3b_wb_t wb
);

lc3b_word regs [`LC3B_NUM_REGS];

// One write port, driven by execute
always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		for (int i = 0; i < `LC3B_NUM_REGS; i++) begin
			regs[i] <= '0;
		end
	end else if (wb.en) begin
		regs[wb.dest] <= wb.value;
	end
end

// Reads are combinational
// forwarding of the same-edge write lives in decode
assign val_a = regs[rd_a];
assign val_b = regs[rd_b];

// Write enable comes from the execute handshake
wb_en_known: assert property (
	@(posedge clk) disable iff (!arst_n)
	!$isunknown(wb.en)
);

endmodule : regfile

// ==== src/control_rom.sv ====
`timescale 1ns/1ps

module control_rom import lc3b_types::*; (
	input lc3b_word inst,
	output lc3b_control_word ctrl
);

always_comb begin
	// Defaults, overridden per opcode below
	ctrl.opcode = lc3b_opcode'(inst[15:12]);
	ctrl.load_cc = 1'b0;
	ctrl.load_regfile = 1'b0;
	ctrl.storemux_sel_two = 1'b0;
	ctrl.alumux_sel = 2'b00;
	ctrl.regfilemux_sel = 3'b000;
	ctrl.immmux_sel = 2'b00;
	ctrl.br_addmux_sel = 1'b0;
	ctrl.branch = 1'b0;
	ctrl.alu_op = alu_add;
	ctrl.mem_read = 1'b0;
	ctrl.mem_write = 1'b0;
	ctrl.mem_byte_enable = 2'b11;

	case (lc3b_opcode'(inst[15:12]))
		// DR <= SR1 + SR2 or imm5
		op_add: begin
			ctrl.alu_op = alu_add;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
			if (inst[5])
				ctrl.alumux_sel = 2'b10;
		end

		// DR <= SR1 & SR2 or imm5
		op_and: begin
			ctrl.alu_op = alu_and;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
			if (inst[5])
				ctrl.alumux_sel = 2'b10;
		end

		op_not: begin
			ctrl.alu_op = alu_not;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
		end

		// Address = base + SEXT(offset6 << 1)
		// Load data never comes back, so no register write
		op_ldr: begin
			ctrl.alumux_sel = 2'b01;
			ctrl.immmux_sel = 2'b01;
			ctrl.br_addmux_sel = 1'b1;
			ctrl.alu_op = alu_add;
			ctrl.regfilemux_sel = 3'b001;
			ctrl.mem_read = 1'b1;
		end

		// Same address, port B reads the source register
		op_str: begin
			ctrl.alumux_sel = 2'b01;
			ctrl.immmux_sel = 2'b01;
			ctrl.br_addmux_sel = 1'b1;
			ctrl.alu_op = alu_add;
			ctrl.storemux_sel_two = 1'b1;
			ctrl.mem_write = 1'b1;
		end

		// Target = PC + 2 + SEXT(offset9 << 1), taken test in execute
		op_br: begin
			ctrl.immmux_sel = 2'b10;
			ctrl.branch = 1'b1;
		end

		// Shift unit does the work
		op_shf: begin
			ctrl.regfilemux_sel = 3'b101;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
		end

		// DR <= PC + 2 + SEXT(offset9 << 1)
		op_lea: begin
			ctrl.immmux_sel = 2'b10;
			ctrl.regfilemux_sel = 3'b010;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
		end

		// Anything else is a no-op
		default: begin
			ctrl = '0;
		end
	endcase
end

endmodule : control_rom

// ==== src/lc3b_types.sv ====
`include "lc3b_defines.svh"

package lc3b_types;

typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
typedef logic [`LC3B_REG_W-1:0] lc3b_reg;

// LC-3b opcode field, bits 15:12
typedef enum logic [3:0] {
	op_br   = 4'b0000,
	op_add  = 4'b0001,
	op_ldb  = 4'b0010,
	op_stb  = 4'b0011,
	op_jsr  = 4'b0100,
	op_and  = 4'b0101,
	op_ldr  = 4'b0110,
	op_str  = 4'b0111,
	op_rti  = 4'b1000,
	op_not  = 4'b1001,
	op_ldi  = 4'b1010,
	op_sti  = 4'b1011,
	op_jmp  = 4'b1100,
	op_shf  = 4'b1101,
	op_lea  = 4'b1110,
	op_trap = 4'b1111
} lc3b_opcode;

typedef enum logic [1:0] {
	alu_add,
	alu_and,
	alu_not,
	alu_pass
} lc3b_aluop;

// Operate layout, also used by SHF (imm is the A bit)
typedef struct packed {
	lc3b_opcode opcode;
	lc3b_reg dr;
	lc3b_reg sr1;
	logic imm;
	logic [4:0] sr2_imm5;
} lc3b_inst_op;

// LDR/STR layout
typedef struct packed {
	lc3b_opcode opcode;
	lc3b_reg dr_sr;
	lc3b_reg base;
	logic [5:0] offset6;
} lc3b_inst_off6;

// BR/LEA layout
typedef struct packed {
	lc3b_opcode opcode;
	logic [2:0] nzp_dr;
	logic [8:0] offset9;
} lc3b_inst_off9;

typedef union packed {
	lc3b_inst_op op;
	lc3b_inst_off6 off6;
	lc3b_inst_off9 off9;
} lc3b_inst;

typedef struct packed {
	lc3b_opcode opcode;
	logic load_cc;
	logic load_regfile;
	logic storemux_sel_two;
	// 00 register B, 01 offset6, 10 imm5
	logic [1:0] alumux_sel;
	// 000 ALU, 001 memory, 010 address adder, 101 shifter
	logic [2:0] regfilemux_sel;
	// 00 imm5, 01 offset6 << 1, 10 offset9 << 1
	logic [1:0] immmux_sel;
	// Address adder base, 0 is PC + 2, 1 is register A
	logic br_addmux_sel;
	logic branch;
	lc3b_aluop alu_op;
	logic mem_read;
	logic mem_write;
	logic [1:0] mem_byte_enable;
} lc3b_control_word;

typedef struct packed {
	lc3b_inst inst;
	lc3b_word pc;
} lc3b_fetch_pkt;

typedef struct packed {
	lc3b_control_word ctrl;
	lc3b_inst inst;
	lc3b_word pc;
	lc3b_word src_a;
	lc3b_word src_b;
	lc3b_word imm;
} lc3b_dx_pkt;

typedef struct packed {
	logic en;
	lc3b_reg dest;
	lc3b_word value;
} lc3b_wb_t;

typedef struct packed {
	lc3b_word pc;
	lc3b_opcode opcode;
	logic wb_en;
	lc3b_reg dest;
	lc3b_word result;
	logic [2:0] cc;
	logic mem_read;
	logic mem_write;
	lc3b_word mem_addr;
	lc3b_word mem_wdata;
	logic br_taken;
	lc3b_word br_target;
} lc3b_retire_pkt;

endpackage : lc3b_types

// ==== include/lc3b_defines.svh ====
`ifndef LC3B_DEFINES_SVH
`define LC3B_DEFINES_SVH

// Data and instruction word width
`define LC3B_WORD_W 16

// Register file size
`define LC3B_NUM_REGS 8

// Bits needed to index one register
`define LC3B_REG_W 3

`endif
